//--- bench/tb_mat_ref.svh
// expected metadata from the instruction rules; each class bit is tested on its own, bit literals
`ifndef TB_MAT_REF_SVH
`define TB_MAT_REF_SVH

// alu word: op, md, ms1 with sign, ms0 with sign, uimm3, element width
function automatic logic [30:0] expect_alu(input logic [31:0] opc, input logic [3:0] mt);
    logic [3:0]  func;
    logic [2:0]  uop;
    logic        size;
    logic [2:0]  u3;
    logic [10:0] op;
    logic        dv;
    logic        s0v;
    logic        s1v;
    logic        uv;
    logic        s0u;
    logic        s1u;
    func = opc[31:28];
    uop  = opc[27:25];
    size = opc[24];
    u3   = opc[9:7];
    op   = 11'd0;
    {dv, s0v, s1v, uv} = 4'b0000;
    s0u  = (u3 == 3'd1) || (u3 == 3'd2); // uu or us
    s1u  = (u3 == 3'd1) || (u3 == 3'd3); // uu or su
    if (mt[0] && func == 4'd1 && uop == 3'd0)
    begin
        op = size ? mat_decd_pkg::MAT_CAL_FWMMACC : mat_decd_pkg::MAT_CAL_FMMACC;
        {dv, s0v, s1v} = 3'b111;
    end
    else if (mt[0] && !size)
    begin
        if (func == 4'd0 && (uop == 3'd0 || uop == 3'd1 || uop == 3'd2))
        begin
            op = mat_decd_pkg::MAT_CAL_MMOV;
            {dv, s0v, uv} = {2'b11, uop == 3'd2};
        end
        else if (func == 4'd2 && uop == 3'd0)
        begin
            op = mat_decd_pkg::MAT_CAL_MMAQA;
            {dv, s0v, s1v} = 3'b111;
        end
        else if (func >= 4'd3 && func <= 4'd9 && uop <= 3'd3)
        begin
            case (func)
                4'd3:    op = mat_decd_pkg::MAT_CAL_MADD;
                4'd4:    op = mat_decd_pkg::MAT_CAL_MSUB;
                4'd5:    op = mat_decd_pkg::MAT_CAL_MSRA;
                4'd6:    op = mat_decd_pkg::MAT_CAL_MN4CLIP;
                4'd7:    op = mat_decd_pkg::MAT_CAL_MN4CLIPU;
                4'd8:    op = mat_decd_pkg::MAT_CAL_MMUL;
                default: op = mat_decd_pkg::MAT_CAL_MMULH;
            endcase
            case (uop)
                3'd2:    {dv, s0v, s1v, uv} = 4'b1111; // .mv.i
                3'd3:    {dv, s0v, s1v, uv} = 4'b1010; // .mx
                default: {dv, s0v, s1v, uv} = 4'b1110;
            endcase
        end
    end
    return {op, dv, opc[17:15], s1v, s1u, opc[23:21], s0v, s0u, opc[20:18], uv, u3, opc[11:10]};
endfunction

// lsu word: op, md, ms3, nf, element width
function automatic logic [15:0] expect_lsu(input logic [31:0] opc, input logic [3:0] mt);
    logic       elem;
    logic       whole;
    logic       ld;
    logic       st;
    logic [1:0] op;
    elem  = mt[1] && opc[31:28] == 4'd0;
    whole = mt[1] && opc[31:28] == 4'd2 && !opc[24];
    ld    = (elem || whole) && opc[27:25] == 3'd4;
    st    = (elem || whole) && opc[27:25] == 3'd5;
    op    = {st, ld};
    return {op, ld, opc[9:7], st, opc[9:7], whole && (ld || st), opc[22:20], opc[11:10]};
endfunction

function automatic logic [3:0] expect_cfg(input logic [31:0] opc, input logic [3:0] mt);
    if (!mt[2] || opc[27:25] != 3'd7)
        return 4'd0;
    if (opc[31:28] == 4'hf)
        return opc[24] ? 4'd0 : mat_decd_pkg::MAT_CFG_ALL;
    case (opc[30:28])
        3'd0:    return mat_decd_pkg::MAT_CFG_K;
        3'd1:    return mat_decd_pkg::MAT_CFG_M;
        3'd2:    return mat_decd_pkg::MAT_CFG_N;
        default: return 4'd0;
    endcase
endfunction

`endif

//--- bench/tb_mat_decd.sv
// decode stage bench; one-cycle latency model, inputs on the falling edge, fixed LFSR seed
`timescale 1ns/1ns

module tb_mat_decd;

    // resets, three class sweeps, uimm3, illegal mix, stall rounds, random traffic, tail
    localparam int STIM_CYCLES    = 2 * 3 + 3 * 256 + 16 + 64 + 4 * 8 + 200 + 4;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;

    logic                      cpuclk;
    logic                      rst_n;
    logic                      decd_vld;
    logic [31:0]               opcode;
    mat_decd_pkg::mat_type_t   mat_type;
    logic                      stall;
    logic                      out_vld;
    mat_decd_pkg::alu_meta_t   alu_meta;
    mat_decd_pkg::lsu_meta_t   lsu_meta;
    mat_decd_pkg::cfg_meta_t   cfg_meta;
    mat_decd_pkg::uimm7_t      cfg_uimm7;

    logic                      exp_vld;   // scoreboard of the last accepted instruction
    logic [30:0]               exp_alu;
    logic [15:0]               exp_lsu;
    logic [3:0]                exp_cfg;
    logic [6:0]                exp_uimm7;
    logic                      model_live;
    logic [31:0]               lfsr;
    int                        errors;
    int                        checks;
    int                        cycle_cnt;

    `include "tb_mat_ref.svh"

    mat_decd_top mat_decd_top_inst (
        .cpuclk    (cpuclk),
        .rst_n     (rst_n),
        .decd_vld  (decd_vld),
        .opcode    (opcode),
        .mat_type  (mat_type),
        .stall     (stall),
        .out_vld   (out_vld),
        .alu_meta  (alu_meta),
        .lsu_meta  (lsu_meta),
        .cfg_meta  (cfg_meta),
        .cfg_uimm7 (cfg_uimm7)
    );

    initial
    begin
        cpuclk = 1'b0;
        forever #4 cpuclk = ~cpuclk;
    end

    // galois step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = 32'd0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] want);
        errors = errors + 1;
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
    endtask

    task automatic send(input logic vld, input logic [31:0] opc, input logic [3:0] mt,
                        input logic stl);
        @(negedge cpuclk);
        decd_vld = vld;
        opcode   = opc;
        mat_type = mt;
        stall    = stl;
    endtask

    // every func/uop/size under one class, other fields random
    task automatic sweep_class(input logic [3:0] mt);
        int          f;
        int          u;
        int          s;
        logic [31:0] fields;
        for (f = 0; f < 16; f++)
            for (u = 0; u < 8; u++)
                for (s = 0; s < 2; s++)
                begin
                    fields = rand_bits(24);
                    send(1'b1, {f[3:0], u[2:0], s[0], fields[23:0]}, mt, 1'b0);
                end
    endtask

    task automatic sweep_uimm3();
        int          u;
        logic [31:0] r;
        for (u = 0; u < 8; u++)
        begin
            r = rand_bits(32);
            send(1'b1, {8'h20, r[23:10], u[2:0], r[6:0]}, mat_decd_pkg::MAT_CAL, 1'b0); // mmaqa
            send(1'b1, {8'h34, r[23:10], u[2:0], r[6:0]}, mat_decd_pkg::MAT_CAL, 1'b0); // madd.mv.i
        end
    endtask

    // special move, no class, random class, load shape under the cfg class
    task automatic illegal_mix(input int n);
        int          i;
        logic [31:0] r;
        logic [31:0] cls;
        for (i = 0; i < n; i++)
        begin
            r = rand_bits(32);
            case (i % 4)
                0:       send(1'b1, r, mat_decd_pkg::MAT_SPECIAL_MOV, 1'b0);
                1:       send(1'b1, r, 4'b0000, 1'b0);
                2:
                begin
                    cls = rand_bits(4);
                    send(1'b1, r, cls[3:0], 1'b0);
                end
                default: send(1'b1, {8'h08, r[23:0]}, mat_decd_pkg::MAT_CFG, 1'b0);
            endcase
        end
    endtask

    task automatic stall_hold(input int cycles);
        logic [58:0] held;
        logic [31:0] r;
        int          i;
        r = rand_bits(32);
        send(1'b1, {8'h44, r[23:0]}, mat_decd_pkg::MAT_CAL, 1'b0);
        send(1'b1, rand_bits(32), mat_decd_pkg::MAT_LSU, 1'b1);
        held = {out_vld, alu_meta, lsu_meta, cfg_meta, cfg_uimm7};
        for (i = 0; i < cycles; i++)
        begin
            r = rand_bits(32);
            send(r[31], r, 4'b0001 << r[1:0], 1'b1);
            assert ({out_vld, alu_meta, lsu_meta, cfg_meta, cfg_uimm7} === held)
                else report_mismatch("held outputs under stall",
                                     {out_vld, alu_meta, lsu_meta, cfg_meta, cfg_uimm7}, held);
        end
        send(1'b0, rand_bits(32), 4'b0000, 1'b0); // release as a bubble
    endtask

    task automatic random_traffic(input int n);
        int          i;
        logic [31:0] sel;
        logic [31:0] r;
        for (i = 0; i < n; i++)
        begin
            sel = rand_bits(4);
            r   = rand_bits(32);
            send(sel[3:2] != 2'b00, r, 4'b0001 << sel[1:0], sel[1:0] == r[1:0]);
        end
    endtask

    // caller sits on a falling edge, or at time zero
    task automatic apply_reset();
        rst_n    = 1'b0;
        decd_vld = 1'b1;
        opcode   = rand_bits(32);
        repeat (2) @(posedge cpuclk);
        @(negedge cpuclk);
        assert ({out_vld, alu_meta, lsu_meta, cfg_meta, cfg_uimm7} === 59'd0)
            else report_mismatch("outputs after reset",
                                 {out_vld, alu_meta, lsu_meta, cfg_meta, cfg_uimm7}, 64'd0);
        rst_n = 1'b1;
    endtask

    always @(posedge cpuclk)
    begin
        model_live <= 1'b1;
        cycle_cnt  <= cycle_cnt + 1;
        if (!rst_n)
        begin
            exp_vld   <= 1'b0;
            exp_alu   <= 31'd0;
            exp_lsu   <= 16'd0;
            exp_cfg   <= 4'd0;
            exp_uimm7 <= 7'd0;
        end
        else if (!stall)
        begin
            exp_vld <= decd_vld;
            if (decd_vld)
            begin
                exp_alu   <= expect_alu(opcode, mat_type);
                exp_lsu   <= expect_lsu(opcode, mat_type);
                exp_cfg   <= expect_cfg(opcode, mat_type);
                exp_uimm7 <= opcode[24:18];
            end
        end
    end

    // outputs settle after the rising edge, compare half a cycle later
    always @(negedge cpuclk)
    begin
        if (model_live)
        begin
            checks = checks + 1;
            assert (out_vld === exp_vld) else report_mismatch("out_vld", out_vld, exp_vld);
            assert (alu_meta === exp_alu) else report_mismatch("alu_meta", alu_meta, exp_alu);
            assert (lsu_meta === exp_lsu) else report_mismatch("lsu_meta", lsu_meta, exp_lsu);
            assert (cfg_meta === exp_cfg) else report_mismatch("cfg_meta", cfg_meta, exp_cfg);
            assert (cfg_uimm7 === exp_uimm7)
                else report_mismatch("cfg_uimm7", cfg_uimm7, exp_uimm7);
        end
    end

    always @(posedge cpuclk)
    begin
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        lfsr       = 32'h7f60;
        errors     = 0;
        checks     = 0;
        cycle_cnt  = 0;
        model_live = 1'b0;
        decd_vld   = 1'b0;
        opcode     = 32'd0;
        mat_type   = 4'd0;
        stall      = 1'b0;
        apply_reset();
        sweep_class(mat_decd_pkg::MAT_CAL);
        sweep_uimm3();
        sweep_class(mat_decd_pkg::MAT_LSU);
        sweep_class(mat_decd_pkg::MAT_CFG);
        illegal_mix(64);
        repeat (4) stall_hold(5);
        random_traffic(200);
        apply_reset();
        send(1'b0, 32'd0, 4'd0, 1'b0);
        repeat (2) @(negedge cpuclk);
        @(posedge cpuclk); // last falling-edge compare is done by now
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- files.f
+incdir+bench
hw/mat_decd_pkg.sv
hw/mat_cal_decd.sv
hw/mat_lsu_decd.sv
hw/mat_cfg_decd.sv
hw/mat_meta_pack.sv
hw/mat_decd_stage.sv
hw/mat_decd_top.sv
bench/tb_mat_decd.sv

//--- hw/mat_cal_decd.sv
// calculation class decoder; combinational, valid only for mat_type with the cal bit set
`timescale 1ns/1ns

module mat_cal_decd (
    input  logic [31:0]              opcode,
    input  mat_decd_pkg::mat_type_t  mat_type,
    output mat_decd_pkg::cal_op_t    cal_op,
    output logic                     dstm_vld,
    output logic                     src0m_vld,
    output logic                     src1m_vld,
    output logic                     uimm3_vld,
    output logic                     src0_unsigned,
    output logic                     src1_unsigned
);

    logic [3:0] func;
    logic [2:0] uop;
    logic       size;
    logic [2:0] uimm3;
    logic       is_cal;

    assign func   = opcode[mat_decd_pkg::OPC_FUNC +: 4];
    assign uop    = opcode[mat_decd_pkg::OPC_UOP +: 3];
    assign size   = opcode[mat_decd_pkg::OPC_SIZE];
    assign uimm3  = opcode[mat_decd_pkg::OPC_LDST +: 3];
    assign is_cal = |(mat_type & mat_decd_pkg::MAT_CAL);

    // uimm3 doubles as the mmaqa signedness selector
    always_comb
    begin
        case (uimm3)
            3'd1:
            begin
                src0_unsigned = 1'b1; // both unsigned
                src1_unsigned = 1'b1;
            end
            3'd2:
            begin
                src0_unsigned = 1'b1; // us
                src1_unsigned = 1'b0;
            end
            3'd3:
            begin
                src0_unsigned = 1'b0; // su
                src1_unsigned = 1'b1;
            end
            default:
            begin
                src0_unsigned = 1'b0; // both signed
                src1_unsigned = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        cal_op    = '0;
        dstm_vld  = 1'b0;
        src0m_vld = 1'b0;
        src1m_vld = 1'b0;
        uimm3_vld = 1'b0;
        if (is_cal)
        begin
            case (func)
                4'd0:
                begin
                    if (!size && uop <= 3'd2) // mmov .mm / .mv.x / .mv.i
                    begin
                        cal_op    = mat_decd_pkg::MAT_CAL_MMOV;
                        dstm_vld  = 1'b1;
                        src0m_vld = 1'b1;
                        uimm3_vld = (uop == 3'd2);
                    end
                end
                4'd1:
                begin
                    if (uop == 3'd0) // size widens to the destination
                    begin
                        cal_op    = size ? mat_decd_pkg::MAT_CAL_FWMMACC
                                         : mat_decd_pkg::MAT_CAL_FMMACC;
                        dstm_vld  = 1'b1;
                        src0m_vld = 1'b1;
                        src1m_vld = 1'b1;
                    end
                end
                4'd2:
                begin
                    if (!size && uop == 3'd0)
                    begin
                        cal_op    = mat_decd_pkg::MAT_CAL_MMAQA;
                        dstm_vld  = 1'b1;
                        src0m_vld = 1'b1;
                        src1m_vld = 1'b1;
                    end
                end
                4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9:
                begin
                    if (!size && uop <= 3'd3)
                    begin
                        // madd..mmulh, one bit per func step
                        cal_op    = mat_decd_pkg::MAT_CAL_MADD << (func - 4'd3);
                        dstm_vld  = 1'b1;
                        src0m_vld = (uop != 3'd3); // .mx has no ms1
                        src1m_vld = 1'b1;
                        uimm3_vld = (uop == 3'd2); // .mv.i
                    end
                end
                default:
                begin
                    cal_op = '0;
                end
            endcase
        end
    end

endmodule

//--- hw/mat_cfg_decd.sv
// matrix size configuration decoder; combinational, func bit 31 ignored except for mcfg
`timescale 1ns/1ns

module mat_cfg_decd (
    input  logic [31:0]              opcode,
    input  mat_decd_pkg::mat_type_t  mat_type,
    output mat_decd_pkg::cfg_op_t    cfg_op
);

    logic [3:0] func;
    logic [2:0] uop;
    logic       size;
    logic       is_cfg;

    assign func   = opcode[mat_decd_pkg::OPC_FUNC +: 4];
    assign uop    = opcode[mat_decd_pkg::OPC_UOP +: 3];
    assign size   = opcode[mat_decd_pkg::OPC_SIZE];
    assign is_cfg = |(mat_type & mat_decd_pkg::MAT_CFG) && uop == 3'd7;

    always_comb
    begin
        cfg_op = '0;
        if (is_cfg)
        begin
            if (func == 4'b1111)
                cfg_op = size ? '0 : mat_decd_pkg::MAT_CFG_ALL; // mcfg
            else
            begin
                case (func[2:0])
                    3'b000:  cfg_op = mat_decd_pkg::MAT_CFG_K;
                    3'b001:  cfg_op = mat_decd_pkg::MAT_CFG_M;
                    3'b010:  cfg_op = mat_decd_pkg::MAT_CFG_N;
                    default: cfg_op = '0;
                endcase
            end
        end
    end

endmodule

//--- hw/mat_decd_pkg.sv
// shared codes, field positions and widths; positions are lsb indices, fixed by the encoding
package mat_decd_pkg;

    typedef logic [3:0]  mat_type_t;   // one-hot class
    typedef logic [10:0] cal_op_t;     // one-hot calculation op
    typedef logic [1:0]  lsu_op_t;
    typedef logic [3:0]  cfg_op_t;
    typedef logic [2:0]  mreg_idx_t;
    typedef logic [1:0]  elem_width_t; // 8/16/32/64
    typedef logic [30:0] alu_meta_t;
    typedef logic [15:0] lsu_meta_t;
    typedef logic [3:0]  cfg_meta_t;
    typedef logic [6:0]  uimm7_t;

    // class codes
    localparam mat_type_t MAT_CAL         = 4'b0001;
    localparam mat_type_t MAT_LSU         = 4'b0010;
    localparam mat_type_t MAT_CFG         = 4'b0100;
    localparam mat_type_t MAT_SPECIAL_MOV = 4'b1000; // never decoded

    // calculation ops, madd to mmulh are consecutive bits
    localparam cal_op_t MAT_CAL_MMOV     = 11'b000_0000_0001;
    localparam cal_op_t MAT_CAL_FMMACC   = 11'b000_0000_0010;
    localparam cal_op_t MAT_CAL_FWMMACC  = 11'b000_0000_0100;
    localparam cal_op_t MAT_CAL_MMAQA    = 11'b000_0000_1000;
    localparam cal_op_t MAT_CAL_MADD     = 11'b000_0001_0000;
    localparam cal_op_t MAT_CAL_MSUB     = 11'b000_0010_0000;
    localparam cal_op_t MAT_CAL_MSRA     = 11'b000_0100_0000;
    localparam cal_op_t MAT_CAL_MN4CLIP  = 11'b000_1000_0000;
    localparam cal_op_t MAT_CAL_MN4CLIPU = 11'b001_0000_0000;
    localparam cal_op_t MAT_CAL_MMUL     = 11'b010_0000_0000;
    localparam cal_op_t MAT_CAL_MMULH    = 11'b100_0000_0000;

    localparam lsu_op_t MAT_LSU_LOAD  = 2'b01;
    localparam lsu_op_t MAT_LSU_STORE = 2'b10;

    localparam cfg_op_t MAT_CFG_K   = 4'b0001;
    localparam cfg_op_t MAT_CFG_M   = 4'b0010;
    localparam cfg_op_t MAT_CFG_N   = 4'b0100;
    localparam cfg_op_t MAT_CFG_ALL = 4'b1000;

    // alu metadata word
    localparam int ALU_OP              = 20; // 30:20
    localparam int ALU_DSTM_VLD        = 19;
    localparam int ALU_DSTM_IDX        = 16; // 18:16
    localparam int ALU_SRC1M_VLD       = 15;
    localparam int ALU_SRC1M_UNSIGNED  = 14;
    localparam int ALU_SRC1M_IDX       = 11; // 13:11
    localparam int ALU_SRC0M_VLD       = 10;
    localparam int ALU_SRC0M_UNSIGNED  = 9;
    localparam int ALU_SRC0M_IDX       = 6;  // 8:6
    localparam int ALU_UIMM3_VLD       = 5;
    localparam int ALU_UIMM3           = 2;  // 4:2
    localparam int ALU_ELM_WIDTH       = 0;  // 1:0

    // lsu metadata word
    localparam int LSU_OP              = 14; // 15:14
    localparam int LSU_DSTM_VLD        = 13;
    localparam int LSU_DSTM_IDX        = 10; // 12:10
    localparam int LSU_SRC2M_VLD       = 9;
    localparam int LSU_SRC2M_IDX       = 6;  // 8:6
    localparam int LSU_NF_VLD          = 5;
    localparam int LSU_NF              = 2;  // 4:2
    localparam int LSU_ELM_WIDTH       = 0;  // 1:0

    // opcode fields
    localparam int OPC_FUNC            = 28; // 31:28
    localparam int OPC_UOP             = 25; // 27:25
    localparam int OPC_SIZE            = 24;
    localparam int OPC_SRC1            = 21; // 23:21
    localparam int OPC_SRC0            = 18; // 20:18
    localparam int OPC_DST             = 15; // 17:15, arithmetic md
    localparam int OPC_ELM_WIDTH       = 10; // 11:10
    localparam int OPC_LDST            = 7;  // 9:7, load md, store ms3, uimm3
    localparam int OPC_NF              = 20; // 22:20
    localparam int OPC_UIMM7           = 18; // 24:18

endpackage

//--- hw/mat_decd_stage.sv
// output register; stall holds everything, upstream must hold its instruction meanwhile
`timescale 1ns/1ns

module mat_decd_stage (
    input  logic                      cpuclk,
    input  logic                      rst_n,
    input  logic                      decd_vld,
    input  logic                      stall,
    input  mat_decd_pkg::alu_meta_t   alu_meta_nxt,
    input  mat_decd_pkg::lsu_meta_t   lsu_meta_nxt,
    input  mat_decd_pkg::cfg_meta_t   cfg_meta_nxt,
    input  mat_decd_pkg::uimm7_t      cfg_uimm7_nxt,
    output logic                      out_vld,
    output mat_decd_pkg::alu_meta_t   alu_meta,
    output mat_decd_pkg::lsu_meta_t   lsu_meta,
    output mat_decd_pkg::cfg_meta_t   cfg_meta,
    output mat_decd_pkg::uimm7_t      cfg_uimm7
);

    logic take;

    assign take = decd_vld && !stall;

    always_ff @(posedge cpuclk)
    begin
        if (!rst_n)
            out_vld <= 1'b0;
        else if (!stall)
            out_vld <= decd_vld; // bubble drops valid only
    end

    always_ff @(posedge cpuclk)
    begin
        if (!rst_n)
        begin
            alu_meta  <= '0;
            lsu_meta  <= '0;
            cfg_meta  <= '0;
            cfg_uimm7 <= '0;
        end
        else if (take)
        begin
            alu_meta  <= alu_meta_nxt;
            lsu_meta  <= lsu_meta_nxt;
            cfg_meta  <= cfg_meta_nxt;
            cfg_uimm7 <= cfg_uimm7_nxt;
        end
    end

endmodule

//--- hw/mat_decd_top.sv
// matrix decode stage top; one cycle latency, special-move class decodes as illegal
`timescale 1ns/1ns

module mat_decd_top (
    input  logic                      cpuclk,
    input  logic                      rst_n,
    input  logic                      decd_vld,
    input  logic [31:0]               opcode,
    input  mat_decd_pkg::mat_type_t   mat_type,
    input  logic                      stall,
    output logic                      out_vld,
    output mat_decd_pkg::alu_meta_t   alu_meta,
    output mat_decd_pkg::lsu_meta_t   lsu_meta,
    output mat_decd_pkg::cfg_meta_t   cfg_meta,
    output mat_decd_pkg::uimm7_t      cfg_uimm7
);

    mat_decd_pkg::cal_op_t     cal_op;
    mat_decd_pkg::lsu_op_t     lsu_op;
    mat_decd_pkg::cfg_op_t     cfg_op;
    logic                      cal_dstm_vld;
    logic                      src0m_vld;
    logic                      src1m_vld;
    logic                      uimm3_vld;
    logic                      src0_unsigned;
    logic                      src1_unsigned;
    logic                      lsu_dstm_vld;
    logic                      src2m_vld;
    logic                      nf_vld;
    mat_decd_pkg::alu_meta_t   alu_meta_nxt;
    mat_decd_pkg::lsu_meta_t   lsu_meta_nxt;
    mat_decd_pkg::cfg_meta_t   cfg_meta_nxt;
    mat_decd_pkg::uimm7_t      cfg_uimm7_nxt;

    mat_cal_decd mat_cal_decd_inst (
        .opcode        (opcode),
        .mat_type      (mat_type),
        .cal_op        (cal_op),
        .dstm_vld      (cal_dstm_vld),
        .src0m_vld     (src0m_vld),
        .src1m_vld     (src1m_vld),
        .uimm3_vld     (uimm3_vld),
        .src0_unsigned (src0_unsigned),
        .src1_unsigned (src1_unsigned)
    );

    mat_lsu_decd mat_lsu_decd_inst (
        .opcode    (opcode),
        .mat_type  (mat_type),
        .lsu_op    (lsu_op),
        .dstm_vld  (lsu_dstm_vld),
        .src2m_vld (src2m_vld),
        .nf_vld    (nf_vld)
    );

    mat_cfg_decd mat_cfg_decd_inst (
        .opcode   (opcode),
        .mat_type (mat_type),
        .cfg_op   (cfg_op)
    );

    mat_meta_pack mat_meta_pack_inst (
        .opcode        (opcode),
        .cal_op        (cal_op),
        .lsu_op        (lsu_op),
        .cfg_op        (cfg_op),
        .cal_dstm_vld  (cal_dstm_vld),
        .src0m_vld     (src0m_vld),
        .src1m_vld     (src1m_vld),
        .uimm3_vld     (uimm3_vld),
        .src0_unsigned (src0_unsigned),
        .src1_unsigned (src1_unsigned),
        .lsu_dstm_vld  (lsu_dstm_vld),
        .src2m_vld     (src2m_vld),
        .nf_vld        (nf_vld),
        .alu_meta      (alu_meta_nxt),
        .lsu_meta      (lsu_meta_nxt),
        .cfg_meta      (cfg_meta_nxt),
        .cfg_uimm7     (cfg_uimm7_nxt)
    );

    mat_decd_stage mat_decd_stage_inst (
        .cpuclk        (cpuclk),
        .rst_n         (rst_n),
        .decd_vld      (decd_vld),
        .stall         (stall),
        .alu_meta_nxt  (alu_meta_nxt),
        .lsu_meta_nxt  (lsu_meta_nxt),
        .cfg_meta_nxt  (cfg_meta_nxt),
        .cfg_uimm7_nxt (cfg_uimm7_nxt),
        .out_vld       (out_vld),
        .alu_meta      (alu_meta),
        .lsu_meta      (lsu_meta),
        .cfg_meta      (cfg_meta),
        .cfg_uimm7     (cfg_uimm7)
    );

endmodule

//--- hw/mat_lsu_decd.sv
// matrix load/store decoder; combinational, nf forms require size 0
`timescale 1ns/1ns

module mat_lsu_decd (
    input  logic [31:0]              opcode,
    input  mat_decd_pkg::mat_type_t  mat_type,
    output mat_decd_pkg::lsu_op_t    lsu_op,
    output logic                     dstm_vld,
    output logic                     src2m_vld,
    output logic                     nf_vld
);

    logic [3:0] func;
    logic [2:0] uop;
    logic       size;
    logic       is_lsu;
    logic       elem_form;
    logic       whole_form;

    assign func   = opcode[mat_decd_pkg::OPC_FUNC +: 4];
    assign uop    = opcode[mat_decd_pkg::OPC_UOP +: 3];
    assign size   = opcode[mat_decd_pkg::OPC_SIZE];
    assign is_lsu = |(mat_type & mat_decd_pkg::MAT_LSU);

    assign elem_form  = is_lsu && func == 4'd0;          // size ignored
    assign whole_form = is_lsu && func == 4'd2 && !size; // mld/mst with nf

    always_comb
    begin
        lsu_op    = '0;
        dstm_vld  = 1'b0;
        src2m_vld = 1'b0;
        nf_vld    = 1'b0;
        if (elem_form || whole_form)
        begin
            if (uop == 3'd4)
            begin
                lsu_op   = mat_decd_pkg::MAT_LSU_LOAD;
                dstm_vld = 1'b1;
                nf_vld   = whole_form;
            end
            else if (uop == 3'd5)
            begin
                lsu_op    = mat_decd_pkg::MAT_LSU_STORE;
                src2m_vld = 1'b1;
                nf_vld    = whole_form;
            end
        end
    end

endmodule

//--- hw/mat_meta_pack.sv
// packs decoder results and raw opcode fields; fields pass through whatever the class
`timescale 1ns/1ns

module mat_meta_pack (
    input  logic [31:0]               opcode,
    input  mat_decd_pkg::cal_op_t     cal_op,
    input  mat_decd_pkg::lsu_op_t     lsu_op,
    input  mat_decd_pkg::cfg_op_t     cfg_op,
    input  logic                      cal_dstm_vld,
    input  logic                      src0m_vld,
    input  logic                      src1m_vld,
    input  logic                      uimm3_vld,
    input  logic                      src0_unsigned,
    input  logic                      src1_unsigned,
    input  logic                      lsu_dstm_vld,
    input  logic                      src2m_vld,
    input  logic                      nf_vld,
    output mat_decd_pkg::alu_meta_t   alu_meta,
    output mat_decd_pkg::lsu_meta_t   lsu_meta,
    output mat_decd_pkg::cfg_meta_t   cfg_meta,
    output mat_decd_pkg::uimm7_t      cfg_uimm7
);

    mat_decd_pkg::mreg_idx_t   dst_idx;
    mat_decd_pkg::mreg_idx_t   src0_idx;
    mat_decd_pkg::mreg_idx_t   src1_idx;
    mat_decd_pkg::mreg_idx_t   ldst_idx; // load md, store ms3 and uimm3 share it
    mat_decd_pkg::elem_width_t elem_width;
    logic [2:0]                nf;       // 1/2/4/8 registers

    assign dst_idx    = opcode[mat_decd_pkg::OPC_DST +: 3];
    assign src0_idx   = opcode[mat_decd_pkg::OPC_SRC0 +: 3];
    assign src1_idx   = opcode[mat_decd_pkg::OPC_SRC1 +: 3];
    assign ldst_idx   = opcode[mat_decd_pkg::OPC_LDST +: 3];
    assign elem_width = opcode[mat_decd_pkg::OPC_ELM_WIDTH +: 2];
    assign nf         = opcode[mat_decd_pkg::OPC_NF +: 3];
    assign cfg_uimm7  = opcode[mat_decd_pkg::OPC_UIMM7 +: 7];

    always_comb
    begin
        alu_meta = '0;
        alu_meta[mat_decd_pkg::ALU_OP +: 11]          = cal_op;
        alu_meta[mat_decd_pkg::ALU_DSTM_VLD]          = cal_dstm_vld;
        alu_meta[mat_decd_pkg::ALU_DSTM_IDX +: 3]     = dst_idx;
        alu_meta[mat_decd_pkg::ALU_SRC1M_VLD]         = src1m_vld;
        alu_meta[mat_decd_pkg::ALU_SRC1M_UNSIGNED]    = src1_unsigned;
        alu_meta[mat_decd_pkg::ALU_SRC1M_IDX +: 3]    = src1_idx;
        alu_meta[mat_decd_pkg::ALU_SRC0M_VLD]         = src0m_vld;
        alu_meta[mat_decd_pkg::ALU_SRC0M_UNSIGNED]    = src0_unsigned;
        alu_meta[mat_decd_pkg::ALU_SRC0M_IDX +: 3]    = src0_idx;
        alu_meta[mat_decd_pkg::ALU_UIMM3_VLD]         = uimm3_vld;
        alu_meta[mat_decd_pkg::ALU_UIMM3 +: 3]        = ldst_idx;
        alu_meta[mat_decd_pkg::ALU_ELM_WIDTH +: 2]    = elem_width;
    end

    always_comb
    begin
        lsu_meta = '0;
        lsu_meta[mat_decd_pkg::LSU_OP +: 2]           = lsu_op;
        lsu_meta[mat_decd_pkg::LSU_DSTM_VLD]          = lsu_dstm_vld;
        lsu_meta[mat_decd_pkg::LSU_DSTM_IDX +: 3]     = ldst_idx;
        lsu_meta[mat_decd_pkg::LSU_SRC2M_VLD]         = src2m_vld;
        lsu_meta[mat_decd_pkg::LSU_SRC2M_IDX +: 3]    = ldst_idx;
        lsu_meta[mat_decd_pkg::LSU_NF_VLD]            = nf_vld;
        lsu_meta[mat_decd_pkg::LSU_NF +: 3]           = nf;
        lsu_meta[mat_decd_pkg::LSU_ELM_WIDTH +: 2]    = elem_width;
    end

    assign cfg_meta = cfg_op; // op is the whole word

endmodule
